// ==== clic/clic_arbiter.sv ====
// ----------------------------------------
// CLIC arbiter
// Per-source config, pending bits, max-level
// selection and the presented interrupt
// ----------------------------------------
`default_nettype none

module clic_arbiter #(
  parameter int unsigned NumSrc = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [NumSrc-1:0]            irq_src_i,    // One pulse per source
  // Source configuration
  input  logic                         cfg_we_i,
  input  logic [$clog2(NumSrc)-1:0]    cfg_id_i,
  input  logic                         cfg_enable_i,
  input  logic [clic_pkg::level_w-1:0] cfg_level_i,
  input  clic_pkg::priv_lvl_t          cfg_priv_i,
  // To/from filter and take path
  input  logic                         irq_ready_i,  // Presented irq taken
  input  logic                         kill_ack_i,   // Retraction granted
  output logic                         irq_valid_o,
  output logic [$clog2(NumSrc)-1:0]    irq_id_o,
  output logic [clic_pkg::level_w-1:0] irq_level_o,
  output clic_pkg::priv_lvl_t          irq_priv_o,
  output logic                         kill_req_o
);
  import clic_pkg::*;

  localparam int unsigned IdW = $clog2(NumSrc);

  logic [NumSrc-1:0]  enable_q;
  logic [level_w-1:0] level_q [NumSrc];
  priv_lvl_t          priv_q  [NumSrc];
  logic [NumSrc-1:0]  src_q;                // Previous source levels
  logic [NumSrc-1:0]  pending_q;
  logic [NumSrc-1:0]  pending_d;
  logic               best_found;
  logic [IdW-1:0]     best_id;
  logic [level_w-1:0] best_level;
  logic               valid_q;              // Presented register
  logic [IdW-1:0]     pres_id_q;
  logic [level_w-1:0] pres_level_q;
  priv_lvl_t          pres_priv_q;

  // ----------------------------------------
  // Configuration registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= '0;  // All sources off
      for (int i = 0; i < NumSrc; i++) begin
        level_q[i] <= '0;
        priv_q[i]  <= PRIV_LVL_M;
      end
    end else if (cfg_we_i) begin
      enable_q[cfg_id_i] <= cfg_enable_i;
      level_q[cfg_id_i]  <= cfg_level_i;
      priv_q[cfg_id_i]   <= cfg_priv_i;
    end
  end

  // Pending bits, latched on rising source edge even when disabled
  always_comb begin
    pending_d = pending_q;
    if (irq_ready_i) begin
      pending_d[pres_id_q] = 1'b0;  // Taken
    end
    pending_d = pending_d | (irq_src_i & ~src_q);  // New edge wins over clear
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_q     <= '0;
      pending_q <= '0;
    end else begin
      src_q     <= irq_src_i;
      pending_q <= pending_d;
    end
  end

  // Highest level wins, strict compare keeps lowest id on ties
  always_comb begin
    best_found = 1'b0;
    best_id    = '0;
    best_level = '0;
    for (int unsigned i = 0; i < NumSrc; i++) begin
      if (pending_q[i] && enable_q[i] && (!best_found || level_q[i] > best_level)) begin
        best_found = 1'b1;
        best_id    = IdW'(i);
        best_level = level_q[i];
      end
    end
  end

  // ----------------------------------------
  // Presented interrupt
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (!valid_q) begin
      valid_q <= best_found;             // Load only when empty
    end else if (irq_ready_i || kill_ack_i) begin
      valid_q <= 1'b0;                   // Reload next cycle
    end
  end

  always_ff @(posedge clk_i) begin
    if (!valid_q && best_found) begin
      pres_id_q    <= best_id;
      pres_level_q <= best_level;
      pres_priv_q  <= priv_q[best_id];
    end
  end

  // Strictly better candidate asks to retract the presented one
  assign kill_req_o  = valid_q && best_found && (best_level > pres_level_q);

  assign irq_valid_o = valid_q;
  assign irq_id_o    = pres_id_q;
  assign irq_level_o = pres_level_q;
  assign irq_priv_o  = pres_priv_q;

endmodule

`default_nettype wire

// ==== clic/clic_irq_filter.sv ====
// ----------------------------------------
// CLIC interrupt filter
// Accepts the presented irq against priv and
// thresholds, packs the cause, acks kills
// ----------------------------------------
`default_nettype none

module clic_irq_filter #(
  parameter int unsigned NumSrc = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // From CSR block
  input  clic_pkg::priv_lvl_t          priv_lvl_i,    // Current privilege
  input  logic                         sie_i,         // Supervisor enable
  input  logic [clic_pkg::level_w-1:0] mintthresh_i,
  input  logic [clic_pkg::level_w-1:0] sintthresh_i,
  input  clic_pkg::intstatus_u         mintstatus_i,
  // From/to arbiter
  input  logic                         irq_valid_i,
  input  logic [$clog2(NumSrc)-1:0]    irq_id_i,
  input  logic [clic_pkg::level_w-1:0] irq_level_i,
  input  clic_pkg::priv_lvl_t          irq_priv_i,
  input  logic                         irq_ready_i,   // Acknowledge from take path
  input  logic                         kill_req_i,
  output logic                         kill_ack_o,
  // To take FSM
  output logic                         irq_req_o,
  output clic_pkg::priv_lvl_t          irq_priv_o,
  output clic_pkg::mcause_u            irq_cause_o
);
  import clic_pkg::*;

  localparam int unsigned IdW = $clog2(NumSrc);

  logic [level_w-1:0] max_mthresh;
  logic [level_w-1:0] max_sthresh;
  logic               inflight_d;
  logic               inflight_q;

  // ----------------------------------------
  // Acceptance
  // ----------------------------------------
  // Effective threshold is the larger of CSR threshold and active level
  assign max_mthresh = (mintthresh_i > mintstatus_i.f.mil) ? mintthresh_i : mintstatus_i.f.mil;
  assign max_sthresh = (sintthresh_i > mintstatus_i.f.sil) ? sintthresh_i : mintstatus_i.f.sil;

  always_comb begin
    irq_req_o = 1'b0;
    case (priv_lvl_i)
      PRIV_LVL_M: begin
        // S irqs never preempt M mode
        irq_req_o = irq_valid_i && (irq_priv_i == PRIV_LVL_M) &&
                    (irq_level_i > max_mthresh);
      end
      PRIV_LVL_S: begin
        if (irq_priv_i == PRIV_LVL_M) begin
          irq_req_o = irq_valid_i;             // Any M irq
        end else if (irq_priv_i == PRIV_LVL_S) begin
          irq_req_o = irq_valid_i && sie_i && (irq_level_i > max_sthresh);
        end
      end
      PRIV_LVL_U: begin
        irq_req_o = irq_valid_i &&
                    ((irq_priv_i == PRIV_LVL_M) ||
                     (irq_priv_i == PRIV_LVL_S && sie_i));
      end
      default: irq_req_o = 1'b0;               // Reserved encoding
    endcase
  end

  assign irq_priv_o = irq_priv_i;

  // ----------------------------------------
  // Cause packing
  // ----------------------------------------
  always_comb begin
    irq_cause_o                = '0;
    irq_cause_o.f.irq          = 1'b1;
    irq_cause_o.f.level        = irq_level_i;  // Lands in mil or sil
    irq_cause_o.f.id[IdW-1:0]  = irq_id_i;
  end

  // ----------------------------------------
  // Kill control
  // ----------------------------------------
  // In flight from accept until ready, or a kill in the same cycle
  assign inflight_d = inflight_q ? ~(irq_ready_i | kill_ack_o) : irq_req_o;

  // No retraction once accepted or while accepting now
  assign kill_ack_o = kill_req_i & ~inflight_q & ~irq_req_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
    end else begin
      inflight_q <= inflight_d;
    end
  end

endmodule

`default_nettype wire

// ==== common/clic_pkg.sv ====
// ----------------------------------------
// CLIC shared definitions
// Privilege encoding, CSR selects, and the
// mintstatus and trap cause word layouts
// ----------------------------------------
`default_nettype none

package clic_pkg;

  localparam int unsigned xlen    = 32;  // Cause word width
  localparam int unsigned level_w = 8;   // Interrupt level width

  // Privilege levels, encoding 2 unused (no hypervisor)
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  // CSR port select
  typedef enum logic [1:0] {
    CSR_CTRL       = 2'd0,  // Priv in [1:0], sie in [2]
    CSR_MINTSTATUS = 2'd1,
    CSR_MINTTHRESH = 2'd2,
    CSR_SINTTHRESH = 2'd3
  } csr_addr_t;

  // ----------------------------------------
  // Interrupt status word
  // ----------------------------------------
  typedef union packed {
    logic [31:0] raw;               // Software view
    struct packed {
      logic [level_w-1:0] mil;      // [31:24] M-mode active level
      logic [7:0]         rsvd_hi;  // [23:16]
      logic [level_w-1:0] sil;      // [15:8] S-mode active level
      logic [7:0]         rsvd_lo;  // [7:0]
    } f;
  } intstatus_u;

  // ----------------------------------------
  // Trap cause word
  // ----------------------------------------
  typedef union packed {
    logic [xlen-1:0] raw;
    struct packed {
      logic               irq;      // [31] Interrupt flag
      logic [6:0]         zero;     // [30:24]
      logic [level_w-1:0] level;    // [23:16] Goes to mil or sil on trap
      logic [15:0]        id;       // [15:0] Source id, upper bits zero
    } f;
  } mcause_u;

endpackage

`default_nettype wire

// ==== logic/clic_subsys_top.sv ====
// ----------------------------------------
// CLIC subsystem top
// Arbiter, filter, take FSM, commit timer
// and interrupt CSRs
// ----------------------------------------
`default_nettype none

module clic_subsys_top #(
  parameter int unsigned NumSrc      = 8,
  parameter int unsigned CommitDelay = 3
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [NumSrc-1:0]            irq_src_i,
  // Source configuration
  input  logic                         cfg_we_i,
  input  logic [$clog2(NumSrc)-1:0]    cfg_id_i,
  input  logic                         cfg_enable_i,
  input  logic [clic_pkg::level_w-1:0] cfg_level_i,
  input  clic_pkg::priv_lvl_t          cfg_priv_i,
  // CSR write port
  input  logic                         csr_we_i,
  input  clic_pkg::csr_addr_t          csr_addr_i,
  input  logic [clic_pkg::xlen-1:0]    csr_wdata_i,
  // Status
  output logic                         trap_valid_o,
  output logic [clic_pkg::xlen-1:0]    trap_cause_o,
  output clic_pkg::priv_lvl_t          priv_lvl_o,
  output clic_pkg::intstatus_u         mintstatus_o
);
  import clic_pkg::*;

  localparam int unsigned IdW = $clog2(NumSrc);

  // ----------------------------------------
  // Interconnect
  // ----------------------------------------
  logic               irq_valid;
  logic [IdW-1:0]     irq_id;
  logic [level_w-1:0] irq_level;
  priv_lvl_t          irq_priv;
  logic               kill_req;
  logic               kill_ack;
  logic               irq_ready;
  logic               irq_req;       // Filter accepts
  priv_lvl_t          req_priv;
  mcause_u            req_cause;
  logic               timer_start;
  logic               timer_done;
  priv_lvl_t          trap_priv;
  mcause_u            trap_cause;
  logic               sie;
  logic [level_w-1:0] mintthresh;
  logic [level_w-1:0] sintthresh;

  clic_arbiter #(
    .NumSrc (NumSrc)
  ) u_arbiter (
    .clk_i, .rst_ni, .irq_src_i,
    .cfg_we_i, .cfg_id_i, .cfg_enable_i, .cfg_level_i, .cfg_priv_i,
    .irq_ready_i (irq_ready),
    .kill_ack_i  (kill_ack),
    .irq_valid_o (irq_valid),
    .irq_id_o    (irq_id),
    .irq_level_o (irq_level),
    .irq_priv_o  (irq_priv),
    .kill_req_o  (kill_req)
  );

  clic_irq_filter #(
    .NumSrc (NumSrc)
  ) u_filter (
    .clk_i, .rst_ni,
    .priv_lvl_i   (priv_lvl_o),
    .sie_i        (sie),
    .mintthresh_i (mintthresh),
    .sintthresh_i (sintthresh),
    .mintstatus_i (mintstatus_o),
    .irq_valid_i  (irq_valid),
    .irq_id_i     (irq_id),
    .irq_level_i  (irq_level),
    .irq_priv_i   (irq_priv),
    .irq_ready_i  (irq_ready),
    .kill_req_i   (kill_req),
    .kill_ack_o   (kill_ack),
    .irq_req_o    (irq_req),
    .irq_priv_o   (req_priv),
    .irq_cause_o  (req_cause)
  );

  irq_take_fsm u_take_fsm (
    .clk_i, .rst_ni,
    .irq_req_i     (irq_req),
    .irq_priv_i    (req_priv),
    .irq_cause_i   (req_cause),
    .timer_done_i  (timer_done),
    .timer_start_o (timer_start),
    .irq_ready_o   (irq_ready),
    .trap_valid_o  (trap_valid_o),
    .trap_priv_o   (trap_priv),
    .trap_cause_o  (trap_cause)
  );

  commit_timer #(
    .CommitDelay (CommitDelay)
  ) u_timer (
    .clk_i, .rst_ni,
    .start_i (timer_start),
    .done_o  (timer_done)
  );

  intr_csr u_csr (
    .clk_i, .rst_ni,
    .csr_we_i, .csr_addr_i, .csr_wdata_i,
    .trap_valid_i (trap_valid_o),
    .trap_priv_i  (trap_priv),
    .trap_cause_i (trap_cause),
    .priv_lvl_o   (priv_lvl_o),
    .sie_o        (sie),
    .mintthresh_o (mintthresh),
    .sintthresh_o (sintthresh),
    .mintstatus_o (mintstatus_o)
  );

  assign trap_cause_o = trap_cause.raw;

endmodule

`default_nettype wire

// ==== logic/commit_timer.sv ====
// ----------------------------------------
// Commit delay timer
// Down-counter, done from zero until restart
// ----------------------------------------
`default_nettype none

module commit_timer #(
  parameter int unsigned CommitDelay = 3
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,  // Pulse, loads CommitDelay
  output logic done_o
);

  localparam int unsigned CntW = (CommitDelay > 0) ? $clog2(CommitDelay + 1) : 1;

  logic [CntW-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CntW'(CommitDelay);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;  // Stops at zero
    end
  end

  // Also high while idle, FSM only looks in COMMIT
  assign done_o = (cnt_q == '0);

endmodule

`default_nettype wire

// ==== logic/intr_csr.sv ====
// ----------------------------------------
// Interrupt CSRs
// Privilege, sie, thresholds and mintstatus,
// written by software and updated on trap
// ----------------------------------------
`default_nettype none

module intr_csr (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Software write port
  input  logic                         csr_we_i,
  input  clic_pkg::csr_addr_t          csr_addr_i,
  input  logic [clic_pkg::xlen-1:0]    csr_wdata_i,
  // Trap update
  input  logic                         trap_valid_i,
  input  clic_pkg::priv_lvl_t          trap_priv_i,
  input  clic_pkg::mcause_u            trap_cause_i,
  // To filter
  output clic_pkg::priv_lvl_t          priv_lvl_o,
  output logic                         sie_o,
  output logic [clic_pkg::level_w-1:0] mintthresh_o,
  output logic [clic_pkg::level_w-1:0] sintthresh_o,
  output clic_pkg::intstatus_u         mintstatus_o
);
  import clic_pkg::*;

  priv_lvl_t          priv_q;
  logic               sie_q;
  logic [level_w-1:0] mintthresh_q;
  logic [level_w-1:0] sintthresh_q;
  intstatus_u         mintstatus_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      priv_q       <= PRIV_LVL_M;  // Core starts in M mode
      sie_q        <= 1'b0;
      mintthresh_q <= '0;
      sintthresh_q <= '0;
      mintstatus_q <= '0;
    end else if (trap_valid_i) begin
      // Trap has priority over a same-cycle write
      priv_q <= trap_priv_i;
      if (trap_priv_i == PRIV_LVL_M) begin
        mintstatus_q.f.mil <= trap_cause_i.f.level;
      end else if (trap_priv_i == PRIV_LVL_S) begin
        mintstatus_q.f.sil <= trap_cause_i.f.level;
      end
    end else if (csr_we_i) begin
      case (csr_addr_i)
        CSR_CTRL: begin
          priv_q <= priv_lvl_t'(csr_wdata_i[1:0]);
          sie_q  <= csr_wdata_i[2];
        end
        CSR_MINTSTATUS: mintstatus_q.raw <= csr_wdata_i[31:0];  // Return path
        CSR_MINTTHRESH: mintthresh_q     <= csr_wdata_i[level_w-1:0];
        CSR_SINTTHRESH: sintthresh_q     <= csr_wdata_i[level_w-1:0];
        default: ;
      endcase
    end
  end

  assign priv_lvl_o   = priv_q;
  assign sie_o        = sie_q;
  assign mintthresh_o = mintthresh_q;
  assign sintthresh_o = sintthresh_q;
  assign mintstatus_o = mintstatus_q;

endmodule

`default_nettype wire

// ==== logic/irq_take_fsm.sv ====
// ----------------------------------------
// Interrupt take FSM
// Stands in for ID/commit: accept, wait the
// commit delay, ack and raise the trap
// ----------------------------------------
`default_nettype none

module irq_take_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  // From filter
  input  logic                irq_req_i,
  input  clic_pkg::priv_lvl_t irq_priv_i,
  input  clic_pkg::mcause_u   irq_cause_i,
  // Commit timer
  input  logic                timer_done_i,
  output logic                timer_start_o,
  // Acknowledge and trap report
  output logic                irq_ready_o,
  output logic                trap_valid_o,
  output clic_pkg::priv_lvl_t trap_priv_o,
  output clic_pkg::mcause_u   trap_cause_o
);
  import clic_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    COMMIT,  // Irq in pipeline, waiting for timer
    ACK      // One cycle, ready and trap pulses
  } state_e;

  state_e    state_d;
  state_e    state_q;
  priv_lvl_t priv_q;
  mcause_u   cause_q;

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_d       = state_q;
    timer_start_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (irq_req_i) begin
          state_d       = COMMIT;
          timer_start_o = 1'b1;      // Timer loads on this edge
        end
      end
      COMMIT: begin
        if (timer_done_i) begin
          state_d = ACK;
        end
      end
      ACK:     state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Trap info captured at acceptance
  always_ff @(posedge clk_i) begin
    if (timer_start_o) begin
      priv_q  <= irq_priv_i;
      cause_q <= irq_cause_i;
    end
  end

  assign irq_ready_o  = (state_q == ACK);
  assign trap_valid_o = (state_q == ACK);  // Same cycle as ready
  assign trap_priv_o  = priv_q;
  assign trap_cause_o = cause_q;

endmodule

`default_nettype wire

// ==== testbench/tb_clic_subsys.sv ====
// ----------------------------------------
// CLIC subsystem testbench
// Directed tests of priv filtering, levels,
// kill retraction and trap reporting
// ----------------------------------------
`default_nettype none

module tb_clic_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  import clic_pkg::*;

  localparam int unsigned NumSrc        = 8;
  localparam int unsigned CommitDelay   = 3;
  localparam int unsigned TrapWait      = 20;    // Per-trap wait window
  // 16 waits of up to 20 cycles plus about 150 cycles of writes, 4x margin
  localparam int unsigned TimeoutCycles = 2000;

  logic                     clk_i;
  logic                     rst_ni;
  logic [NumSrc-1:0]        irq_src;
  logic                     cfg_we;
  logic [$clog2(NumSrc)-1:0] cfg_id;
  logic                     cfg_enable;
  logic [level_w-1:0]       cfg_level;
  priv_lvl_t                cfg_priv;
  logic                     csr_we;
  csr_addr_t                csr_addr;
  logic [xlen-1:0]          csr_wdata;
  logic                     trap_valid;
  logic [xlen-1:0]          trap_cause;
  priv_lvl_t                priv_lvl;
  intstatus_u               mintstatus;

  int    errors    = 0;
  int    checks    = 0;
  int    cycle_cnt = 0;
  string test_name = "reset";

  clic_subsys_top #(
    .NumSrc      (NumSrc),
    .CommitDelay (CommitDelay)
  ) u_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .irq_src_i    (irq_src),
    .cfg_we_i     (cfg_we),
    .cfg_id_i     (cfg_id),
    .cfg_enable_i (cfg_enable),
    .cfg_level_i  (cfg_level),
    .cfg_priv_i   (cfg_priv),
    .csr_we_i     (csr_we),
    .csr_addr_i   (csr_addr),
    .csr_wdata_i  (csr_wdata),
    .trap_valid_o (trap_valid),
    .trap_cause_o (trap_cause),
    .priv_lvl_o   (priv_lvl),
    .mintstatus_o (mintstatus)
  );

  // 20 ns period
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Watchdog on total run length
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Run did not finish within %0d cycles", TimeoutCycles);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("Errors found");
      $finish;
    end
  end

  // ----------------------------------------
  // Expected values and checks
  // ----------------------------------------
  // irq flag, level in 23:16, id in the low bits
  function automatic logic [31:0] packed_cause(input int id, input logic [7:0] level);
    return {1'b1, 7'd0, level, 16'(id)};
  endfunction

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERROR %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
    end
  endtask

  // ----------------------------------------
  // Drivers act on the falling edge
  // ----------------------------------------
  task automatic csr_write(input csr_addr_t addr, input logic [31:0] data);
    @(negedge clk_i);
    csr_we    = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    @(negedge clk_i);
    csr_we    = 1'b0;
  endtask

  task automatic write_ctrl(input priv_lvl_t priv, input logic sie);
    csr_write(CSR_CTRL, {29'd0, sie, priv});
  endtask

  // Mode, enable, cleared status, thresholds
  task automatic prepare_mode(input priv_lvl_t priv, input logic sie,
                              input logic [7:0] mth, input logic [7:0] sth);
    write_ctrl(priv, sie);
    csr_write(CSR_MINTSTATUS, 32'd0);
    csr_write(CSR_MINTTHRESH, {24'd0, mth});
    csr_write(CSR_SINTTHRESH, {24'd0, sth});
  endtask

  // Software return from a handler
  task automatic return_to(input priv_lvl_t priv, input logic sie);
    write_ctrl(priv, sie);
    csr_write(CSR_MINTSTATUS, 32'd0);
  endtask

  task automatic configure_source(input int id, input logic en,
                                  input logic [7:0] level, input priv_lvl_t priv);
    @(negedge clk_i);
    cfg_we     = 1'b1;
    cfg_id     = id[2:0];
    cfg_enable = en;
    cfg_level  = level;
    cfg_priv   = priv;
    @(negedge clk_i);
    cfg_we     = 1'b0;
  endtask

  // One-cycle pulse on each source in mask
  task automatic pulse_sources(input logic [NumSrc-1:0] mask);
    @(negedge clk_i);
    irq_src = mask;
    @(negedge clk_i);
    irq_src = '0;
  endtask

  // Pulse on first, then on second one cycle later
  task automatic pulse_back_to_back(input logic [NumSrc-1:0] first,
                                    input logic [NumSrc-1:0] second);
    @(negedge clk_i);
    irq_src = first;
    @(negedge clk_i);
    irq_src = second;
    @(negedge clk_i);
    irq_src = '0;
  endtask

  // trap_valid is stable at the sampling negedge
  task automatic wait_trap(output logic seen, output logic [31:0] cause, output int waited);
    seen   = 1'b0;
    cause  = '0;
    waited = 0;
    while (!seen && waited < TrapWait) begin
      @(negedge clk_i);
      waited++;
      if (trap_valid) begin
        seen  = 1'b1;
        cause = trap_cause;
      end
    end
  endtask

  task automatic expect_trap(input int id, input logic [7:0] level, output int waited);
    logic        seen;
    logic [31:0] cause;
    wait_trap(seen, cause, waited);
    checks++;
    if (!seen) begin
      errors++;
      $display("%s: no trap from source %0d within %0d cycles", test_name, id, TrapWait);
    end else begin
      compare("cause", packed_cause(id, level), cause);
    end
  endtask

  task automatic expect_no_trap();
    checks++;
    repeat (TrapWait) begin
      @(negedge clk_i);
      if (trap_valid) begin
        errors++;
        $display("%s: unexpected trap with cause 0x%0h", test_name, trap_cause);
      end
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic m_irq_from_u_mode();
    int waited;
    test_name = "u_mode_m_irq";
    prepare_mode(PRIV_LVL_U, 1'b0, 8'd0, 8'd0);
    configure_source(1, 1'b1, 8'd40, PRIV_LVL_M);
    pulse_sources(8'b0000_0010);
    expect_trap(1, 8'd40, waited);
    compare("latency", 32'(3 + CommitDelay), 32'(waited));  // Counted from pulse edge
    @(negedge clk_i);  // CSR update lands on the edge after the trap
    compare("priv", {30'd0, PRIV_LVL_M}, {30'd0, priv_lvl});
    compare("mil", 32'd40, {24'd0, mintstatus.f.mil});
  endtask

  task automatic threshold_hold();
    int waited;
    test_name = "threshold";
    prepare_mode(PRIV_LVL_M, 1'b0, 8'd50, 8'd0);
    configure_source(2, 1'b1, 8'd40, PRIV_LVL_M);
    pulse_sources(8'b0000_0100);
    expect_no_trap();                      // 40 not above 50
    csr_write(CSR_MINTTHRESH, 32'd10);
    expect_trap(2, 8'd40, waited);         // Still pending
    @(negedge clk_i);
    compare("mil", 32'd40, {24'd0, mintstatus.f.mil});
  endtask

  task automatic s_irq_sie_gate();
    int waited;
    test_name = "s_irq_sie";
    prepare_mode(PRIV_LVL_U, 1'b0, 8'd0, 8'd0);
    configure_source(3, 1'b1, 8'd60, PRIV_LVL_S);
    pulse_sources(8'b0000_1000);
    expect_no_trap();
    write_ctrl(PRIV_LVL_U, 1'b1);
    expect_trap(3, 8'd60, waited);
    @(negedge clk_i);
    compare("priv", {30'd0, PRIV_LVL_S}, {30'd0, priv_lvl});
    compare("sil", 32'd60, {24'd0, mintstatus.f.sil});
    // M mode ignores S irqs even with sie set
    test_name = "s_irq_in_m_mode";
    prepare_mode(PRIV_LVL_M, 1'b1, 8'd0, 8'd0);
    pulse_sources(8'b0000_1000);
    expect_no_trap();
    return_to(PRIV_LVL_U, 1'b1);           // Drain the held source
    expect_trap(3, 8'd60, waited);
  endtask

  task automatic level_and_kill_order();
    int waited;
    test_name = "level_order";
    prepare_mode(PRIV_LVL_U, 1'b0, 8'd0, 8'd0);
    configure_source(4, 1'b1, 8'd20, PRIV_LVL_M);
    configure_source(5, 1'b1, 8'd90, PRIV_LVL_M);
    pulse_sources(8'b0011_0000);
    expect_trap(5, 8'd90, waited);
    return_to(PRIV_LVL_U, 1'b0);
    expect_trap(4, 8'd20, waited);
    // Low source held by the threshold and retracted by the kill
    test_name = "kill_order";
    prepare_mode(PRIV_LVL_M, 1'b0, 8'd50, 8'd0);
    pulse_back_to_back(8'b0001_0000, 8'b0010_0000);
    expect_trap(5, 8'd90, waited);
    return_to(PRIV_LVL_U, 1'b0);
    expect_trap(4, 8'd20, waited);
  endtask

  task automatic disabled_source_hold();
    int waited;
    test_name = "disabled_source";
    prepare_mode(PRIV_LVL_U, 1'b0, 8'd0, 8'd0);
    configure_source(6, 1'b0, 8'd70, PRIV_LVL_M);
    pulse_sources(8'b0100_0000);
    expect_no_trap();
    configure_source(6, 1'b1, 8'd70, PRIV_LVL_M);
    expect_trap(6, 8'd70, waited);         // Earlier pulse kept
  endtask

  task automatic equal_level_order();
    int waited;
    test_name = "equal_levels";
    prepare_mode(PRIV_LVL_U, 1'b0, 8'd0, 8'd0);
    configure_source(0, 1'b1, 8'd55, PRIV_LVL_M);
    configure_source(2, 1'b1, 8'd55, PRIV_LVL_M);
    configure_source(7, 1'b1, 8'd55, PRIV_LVL_M);
    pulse_sources(8'b1000_0101);
    expect_trap(0, 8'd55, waited);         // Lowest id first
    return_to(PRIV_LVL_U, 1'b0);
    expect_trap(2, 8'd55, waited);
    return_to(PRIV_LVL_U, 1'b0);
    expect_trap(7, 8'd55, waited);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    rst_ni     = 1'b0;
    irq_src    = '0;
    cfg_we     = 1'b0;
    cfg_id     = '0;
    cfg_enable = 1'b0;
    cfg_level  = '0;
    cfg_priv   = PRIV_LVL_M;
    csr_we     = 1'b0;
    csr_addr   = CSR_CTRL;
    csr_wdata  = '0;
    repeat (3) @(negedge clk_i);           // Reset for 3 cycles
    rst_ni = 1'b1;

    m_irq_from_u_mode();
    threshold_hold();
    s_irq_sie_gate();
    level_and_kill_order();
    disabled_source_hold();
    equal_level_order();

    repeat (2) @(negedge clk_i);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/clic_pkg.sv
clic/clic_arbiter.sv
clic/clic_irq_filter.sv
logic/irq_take_fsm.sv
logic/commit_timer.sv
logic/intr_csr.sv
logic/clic_subsys_top.sv
testbench/tb_clic_subsys.sv
